// File: hdl/cfg_table.sv
// read and write configuration tables with load port and registered lookup
`timescale 1ns/100ps

module cfg_table (
  input  logic                    clk,
  input  mem_ctrl_pkg::cfg_load_t cfg_load,
  input  mem_ctrl_pkg::rd_idx_t   rd_idx,
  input  mem_ctrl_pkg::wr_idx_t   wr_idx,
  output mem_ctrl_pkg::rd_cfg_t   rd_entry,
  output mem_ctrl_pkg::wr_cfg_t   wr_entry
);

  mem_ctrl_pkg::rd_cfg_t rd_mem [mem_ctrl_pkg::RD_DEPTH];
  mem_ctrl_pkg::wr_cfg_t wr_mem [mem_ctrl_pkg::WR_DEPTH];

  // ********************************************************************
  // load port writes one entry per cycle
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (cfg_load.we && !cfg_load.sel_wr) begin
      rd_mem[cfg_load.idx[mem_ctrl_pkg::RD_IDX_W-1:0]] <= cfg_load.rd_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_load.we && cfg_load.sel_wr) begin
      wr_mem[cfg_load.idx[mem_ctrl_pkg::WR_IDX_W-1:0]] <= cfg_load.wr_entry;
    end
  end

  // ********************************************************************
  // lookup valid one cycle after the index moves
  // ********************************************************************
  always_ff @(posedge clk) begin
    rd_entry <= rd_mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    wr_entry <= wr_mem[wr_idx];
  end

  // a load must name a known table and entry
  a_load_idx: assert property (@(posedge clk)
    cfg_load.we |-> !$isunknown({cfg_load.sel_wr, cfg_load.idx}));

endmodule

// File: hdl/loop_counter.sv
// wrapping up-counter with clear and programmable maximum
`timescale 1ns/100ps

module loop_counter #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  logic             inc,
  input  logic [WIDTH-1:0] max_count,
  output logic [WIDTH-1:0] count,
  output logic             last
);

  // ********************************************************************
  // count register
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (inc) begin
      if (last) begin
        count <= '0;               // wrap after the final step
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // high for the whole final step, not just on the wrap
  assign last = (count == max_count);

endmodule

// File: hdl/mem_controller.sv
// memory controller top with configuration tables, read and write sequencers
`timescale 1ns/100ps

module mem_controller (
  input  logic                    clk,
  input  logic                    reset,
  input  mem_ctrl_pkg::cfg_load_t cfg_load,
  input  mem_ctrl_pkg::rd_idx_t   rd_last_idx,
  input  mem_ctrl_pkg::wr_idx_t   wr_last_idx,
  input  logic                    start,
  output logic                    done,
  output logic                    rd_req,
  input  logic                    rd_ready,
  output mem_ctrl_pkg::rd_cmd_t   rd_cmd,
  output logic                    wr_req,
  input  logic                    wr_ready,
  input  logic                    wr_done,
  output mem_ctrl_pkg::wr_cmd_t   wr_cmd,
  output mem_ctrl_pkg::rd_idx_t   rd_cfg_idx,
  output mem_ctrl_pkg::wr_idx_t   wr_cfg_idx
);

  mem_ctrl_pkg::rd_cfg_t rd_entry;
  mem_ctrl_pkg::wr_cfg_t wr_entry;
  logic                  rd_active;   // read side out of idle

  cfg_table cfg_table_i (
    .clk(clk), .cfg_load(cfg_load), .rd_idx(rd_cfg_idx), .wr_idx(wr_cfg_idx),
    .rd_entry(rd_entry), .wr_entry(wr_entry)
  );

  read_sequencer read_sequencer_i (
    .clk(clk), .reset(reset), .start(start), .rd_last_idx(rd_last_idx),
    .rd_entry(rd_entry), .wr_idx(wr_cfg_idx), .rd_ready(rd_ready), .rd_req(rd_req),
    .rd_cmd(rd_cmd), .rd_idx(rd_cfg_idx), .rd_active(rd_active)
  );

  write_sequencer write_sequencer_i (
    .clk(clk), .reset(reset), .rd_active(rd_active), .wr_last_idx(wr_last_idx),
    .wr_entry(wr_entry), .wr_ready(wr_ready), .wr_done(wr_done), .wr_req(wr_req),
    .wr_cmd(wr_cmd), .wr_idx(wr_cfg_idx), .done(done)
  );

endmodule

// File: hdl/mem_ctrl_pkg.sv
// widths, vector types, fsm state enums and packed config and command structs
package mem_ctrl_pkg;

  // ********************************************************************
  // widths and sizes
  // ********************************************************************
  localparam int ADDR_W     = 32;
  localparam int TX_SIZE_W  = 10;
  localparam int LOOP_W     = 16;
  localparam int NUM_PU     = 2;
  localparam int PU_ID_W    = 2;
  localparam int RD_IDX_W   = 3;
  localparam int WR_IDX_W   = 3;
  localparam int RD_DEPTH   = 2**RD_IDX_W;   // read table entries
  localparam int WR_DEPTH   = 2**WR_IDX_W;   // write table entries
  localparam int LOAD_IDX_W = (RD_IDX_W > WR_IDX_W) ? RD_IDX_W : WR_IDX_W;

  typedef logic [ADDR_W-1:0]    addr_t;      // address or address step
  typedef logic [TX_SIZE_W-1:0] tx_size_t;   // request size
  typedef logic [LOOP_W-1:0]    loop_t;      // loop max or loop count
  typedef logic [PU_ID_W-1:0]   pu_id_t;
  typedef logic [RD_IDX_W-1:0]  rd_idx_t;
  typedef logic [WR_IDX_W-1:0]  wr_idx_t;

  // ********************************************************************
  // table entries
  // ********************************************************************
  typedef struct packed {
    addr_t    buf_base;          // buffer reads restart here when i is 0
    addr_t    buf_offset;
    loop_t    buf_loop_max;      // buffer reads per stream step, minus one
    tx_size_t buf_size;
    addr_t    stm_base;
    addr_t    stm_loop0_offset;  // step of loop i
    loop_t    stm_loop0_max;
    addr_t    stm_loop1_offset;  // step of loop j
    loop_t    stm_loop1_max;
    tx_size_t stm_size;
  } rd_cfg_t;

  typedef struct packed {
    addr_t    base;
    addr_t    offset;
    loop_t    loop_max;          // writes per entry, minus one
    tx_size_t size;
  } wr_cfg_t;

  // one item of the table load port
  typedef struct packed {
    logic                  we;
    logic                  sel_wr;   // 0 read table, 1 write table
    logic [LOAD_IDX_W-1:0] idx;
    rd_cfg_t               rd_entry;
    wr_cfg_t               wr_entry;
  } cfg_load_t;

  // ********************************************************************
  // memory commands
  // ********************************************************************
  typedef struct packed {
    addr_t    addr;
    tx_size_t size;
    pu_id_t   pu_id;
    logic     is_buffer;   // buffer read, else stream read
  } rd_cmd_t;

  typedef struct packed {
    addr_t    addr;
    tx_size_t size;
    pu_id_t   pu_id;
  } wr_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    CFG_BUFFER,
    BUSY_BUFFER,
    CFG_STREAM,
    BUSY_STREAM
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_CFG,
    WR_BUSY,
    WR_WAIT_DONE
  } wr_state_e;

endpackage

// File: hdl/read_sequencer.sv
// read fsm, buffer and stream loop counters, read address generation and throttle
`timescale 1ns/100ps

module read_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  mem_ctrl_pkg::rd_idx_t rd_last_idx,
  input  mem_ctrl_pkg::rd_cfg_t rd_entry,
  input  mem_ctrl_pkg::wr_idx_t wr_idx,
  input  logic                  rd_ready,
  output logic                  rd_req,
  output mem_ctrl_pkg::rd_cmd_t rd_cmd,
  output mem_ctrl_pkg::rd_idx_t rd_idx,
  output logic                  rd_active
);

  mem_ctrl_pkg::rd_state_e state;
  mem_ctrl_pkg::rd_state_e state_next;
  logic                    in_cfg;
  logic                    cfg_hold;     // second cfg cycle with a valid entry
  logic                    throttle_q;
  logic                    run_start;
  logic                    buf_issue;
  logic                    stm_issue;
  logic                    loop1_inc;
  logic                    idx_inc;
  logic                    all_reads_done;
  mem_ctrl_pkg::loop_t     buf_count;    // k
  mem_ctrl_pkg::loop_t     loop0_count;  // i
  mem_ctrl_pkg::loop_t     loop1_count;  // j
  logic                    buf_last;
  logic                    loop0_last;
  logic                    loop1_last;
  logic                    idx_last;
  mem_ctrl_pkg::addr_t     buf_addr;
  mem_ctrl_pkg::addr_t     loop1_addr;   // stm_base + j * loop1 offset
  mem_ctrl_pkg::addr_t     stm_addr;

  assign run_start = (state == mem_ctrl_pkg::IDLE) && start;
  assign in_cfg    = (state == mem_ctrl_pkg::CFG_BUFFER) || (state == mem_ctrl_pkg::CFG_STREAM);
  assign rd_active = (state != mem_ctrl_pkg::IDLE);

  // ********************************************************************
  // throttle and issue
  // ********************************************************************
  assign rd_req = ((state == mem_ctrl_pkg::BUSY_BUFFER) || (state == mem_ctrl_pkg::BUSY_STREAM))
                  && rd_ready && !throttle_q;
  assign buf_issue = rd_req && (state == mem_ctrl_pkg::BUSY_BUFFER);
  assign stm_issue = rd_req && (state == mem_ctrl_pkg::BUSY_STREAM);

  always_ff @(posedge clk) begin
    if (reset) begin
      throttle_q <= 1'b0;
    end else begin
      throttle_q <= rd_req || (rd_idx > wr_idx);  // spacing then write side
    end
  end

  // loop nesting k inside i inside j inside entry
  assign loop1_inc      = stm_issue && loop0_last;
  assign idx_inc        = loop1_inc && loop1_last;
  assign all_reads_done = idx_inc && idx_last;

  loop_counter #(.WIDTH(mem_ctrl_pkg::LOOP_W)) buf_counter_i (
    .clk(clk), .reset(reset), .clear(run_start), .inc(buf_issue),
    .max_count(rd_entry.buf_loop_max), .count(buf_count), .last(buf_last)
  );

  loop_counter #(.WIDTH(mem_ctrl_pkg::LOOP_W)) loop0_counter_i (
    .clk(clk), .reset(reset), .clear(run_start), .inc(stm_issue),
    .max_count(rd_entry.stm_loop0_max), .count(loop0_count), .last(loop0_last)
  );

  loop_counter #(.WIDTH(mem_ctrl_pkg::LOOP_W)) loop1_counter_i (
    .clk(clk), .reset(reset), .clear(run_start), .inc(loop1_inc),
    .max_count(rd_entry.stm_loop1_max), .count(loop1_count), .last(loop1_last)
  );

  loop_counter #(.WIDTH(mem_ctrl_pkg::RD_IDX_W)) idx_counter_i (
    .clk(clk), .reset(reset), .clear(run_start), .inc(idx_inc),
    .max_count(rd_last_idx), .count(rd_idx), .last(idx_last)
  );

  // ********************************************************************
  // address generation
  // ********************************************************************
  always_ff @(posedge clk) begin
    if ((state == mem_ctrl_pkg::CFG_BUFFER) && cfg_hold && (loop0_count == '0)
        && (buf_count == '0)) begin
      buf_addr <= rd_entry.buf_base;             // first group of a stream row
    end else if (buf_issue) begin
      buf_addr <= buf_addr + rd_entry.buf_offset;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == mem_ctrl_pkg::CFG_STREAM) && cfg_hold && (loop0_count == '0)) begin
      if (loop1_count == '0) begin
        loop1_addr <= rd_entry.stm_base;
        stm_addr   <= rd_entry.stm_base;
      end else begin
        stm_addr   <= loop1_addr;                // new row of loop j
      end
    end else if (stm_issue) begin
      stm_addr <= stm_addr + rd_entry.stm_loop0_offset;
      if (loop0_last) begin
        loop1_addr <= loop1_addr + rd_entry.stm_loop1_offset;
      end
    end
  end

  always_comb begin
    if (state == mem_ctrl_pkg::BUSY_BUFFER) begin
      rd_cmd.addr      = buf_addr;
      rd_cmd.size      = rd_entry.buf_size;
      rd_cmd.pu_id     = buf_count[mem_ctrl_pkg::PU_ID_W-1:0];
      rd_cmd.is_buffer = 1'b1;
    end else begin
      rd_cmd.addr      = stm_addr;
      rd_cmd.size      = rd_entry.stm_size;
      rd_cmd.pu_id     = '0;
      rd_cmd.is_buffer = 1'b0;
    end
  end

  // ********************************************************************
  // fsm
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= mem_ctrl_pkg::IDLE;
      cfg_hold <= 1'b0;
    end else begin
      state    <= state_next;
      cfg_hold <= in_cfg && !cfg_hold;           // each cfg state is 2 cycles
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      mem_ctrl_pkg::IDLE: begin
        if (start) state_next = mem_ctrl_pkg::CFG_BUFFER;
      end
      mem_ctrl_pkg::CFG_BUFFER: begin
        if (cfg_hold) state_next = mem_ctrl_pkg::BUSY_BUFFER;
      end
      mem_ctrl_pkg::BUSY_BUFFER: begin
        if (buf_issue) begin
          state_next = buf_last ? mem_ctrl_pkg::CFG_STREAM : mem_ctrl_pkg::CFG_BUFFER;
        end
      end
      mem_ctrl_pkg::CFG_STREAM: begin
        if (cfg_hold) state_next = mem_ctrl_pkg::BUSY_STREAM;
      end
      mem_ctrl_pkg::BUSY_STREAM: begin
        if (all_reads_done) state_next = mem_ctrl_pkg::IDLE;
        else if (stm_issue) state_next = mem_ctrl_pkg::CFG_BUFFER;
      end
      default: state_next = mem_ctrl_pkg::IDLE;
    endcase
  end

  // registered throttle must still keep reads behind the write entry
  a_req_idx: assert property (@(posedge clk) disable iff (reset)
    rd_req |-> (rd_idx <= wr_idx));
  a_buf_range: assert property (@(posedge clk) disable iff (reset)
    buf_issue |-> (buf_count <= rd_entry.buf_loop_max));

endmodule

// File: hdl/write_sequencer.sv
// write fsm, write loop, round-robin pu id, write entry index and done pulse
`timescale 1ns/100ps

module write_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  rd_active,
  input  mem_ctrl_pkg::wr_idx_t wr_last_idx,
  input  mem_ctrl_pkg::wr_cfg_t wr_entry,
  input  logic                  wr_ready,
  input  logic                  wr_done,
  output logic                  wr_req,
  output mem_ctrl_pkg::wr_cmd_t wr_cmd,
  output mem_ctrl_pkg::wr_idx_t wr_idx,
  output logic                  done
);

  mem_ctrl_pkg::wr_state_e state;
  mem_ctrl_pkg::wr_state_e state_next;
  logic                    cfg_hold;
  logic                    spent;       // this run's writes are finished
  logic                    wr_start;
  logic                    entry_adv;
  logic                    count_last;
  logic                    idx_last;
  mem_ctrl_pkg::pu_id_t    pu_id;
  mem_ctrl_pkg::addr_t     wr_addr;

  assign wr_start  = (state == mem_ctrl_pkg::WR_IDLE) && wr_ready && rd_active && !spent;
  assign entry_adv = (state == mem_ctrl_pkg::WR_WAIT_DONE) && wr_done;
  assign done      = entry_adv && idx_last;
  assign wr_req    = (state == mem_ctrl_pkg::WR_BUSY) && wr_ready && !wr_done;

  // ********************************************************************
  // counters
  // ********************************************************************
  loop_counter #(.WIDTH(mem_ctrl_pkg::LOOP_W)) wr_counter_i (
    .clk(clk), .reset(reset), .clear(wr_start), .inc(wr_req),
    .max_count(wr_entry.loop_max), .count(), .last(count_last)
  );

  // round robin over the pus restarting with every entry
  loop_counter #(.WIDTH(mem_ctrl_pkg::PU_ID_W)) pu_counter_i (
    .clk(clk), .reset(reset), .clear(entry_adv), .inc(wr_req),
    .max_count(mem_ctrl_pkg::pu_id_t'(mem_ctrl_pkg::NUM_PU - 1)), .count(pu_id), .last()
  );

  // holds at the last entry after done so a slower read side stays unthrottled
  loop_counter #(.WIDTH(mem_ctrl_pkg::WR_IDX_W)) idx_counter_i (
    .clk(clk), .reset(reset), .clear(wr_start), .inc(entry_adv && !idx_last),
    .max_count(wr_last_idx), .count(wr_idx), .last(idx_last)
  );

  // ********************************************************************
  // write address
  // ********************************************************************
  always_ff @(posedge clk) begin
    if ((state == mem_ctrl_pkg::WR_CFG) && cfg_hold) begin
      wr_addr <= wr_entry.base;
    end else if (wr_req) begin
      wr_addr <= wr_addr + wr_entry.offset;
    end
  end

  assign wr_cmd.addr  = wr_addr;
  assign wr_cmd.size  = wr_entry.size;
  assign wr_cmd.pu_id = pu_id;

  // ********************************************************************
  // fsm
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= mem_ctrl_pkg::WR_IDLE;
      cfg_hold <= 1'b0;
      spent    <= 1'b0;
    end else begin
      state    <= state_next;
      cfg_hold <= (state == mem_ctrl_pkg::WR_CFG) && !cfg_hold;
      if (done) spent <= 1'b1;                 // one pass per read run
      else if (!rd_active) spent <= 1'b0;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      mem_ctrl_pkg::WR_IDLE: begin
        if (wr_start) state_next = mem_ctrl_pkg::WR_CFG;
      end
      mem_ctrl_pkg::WR_CFG: begin
        if (cfg_hold) state_next = mem_ctrl_pkg::WR_BUSY;
      end
      mem_ctrl_pkg::WR_BUSY: begin
        if (wr_req && count_last) state_next = mem_ctrl_pkg::WR_WAIT_DONE;
      end
      mem_ctrl_pkg::WR_WAIT_DONE: begin
        if (wr_done) state_next = idx_last ? mem_ctrl_pkg::WR_IDLE : mem_ctrl_pkg::WR_CFG;
      end
      default: state_next = mem_ctrl_pkg::WR_IDLE;
    endcase
  end

  // pu id and entry index stay inside their ranges while writing
  a_wr_req_range: assert property (@(posedge clk) disable iff (reset)
    wr_req |-> (int'(pu_id) < mem_ctrl_pkg::NUM_PU) && (wr_idx <= wr_last_idx));

endmodule

// File: sim.f
+incdir+tests
hdl/mem_ctrl_pkg.sv
hdl/loop_counter.sv
hdl/cfg_table.sv
hdl/read_sequencer.sv
hdl/write_sequencer.sv
hdl/mem_controller.sv
tests/mem_controller_tb.sv

// File: tests/mem_controller_tests.svh
// directed test tasks, table loading, reference command model and result checks

  function automatic logic random_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // wr_done follows the last write by 1 to 4 cycles
  function automatic int random_delay();
    logic [31:0] r;
    r = $random(seed);
    return 1 + int'(r[1:0]);
  endfunction

  task automatic flag_error(input string what);
    $display("%s: %s", test_name, what);
    err_count++;
  endtask

  task automatic value_error(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
    err_count++;
  endtask

  function automatic mem_ctrl_pkg::rd_cfg_t build_rd_entry(
    input int buf_base, input int buf_offset, input int buf_max, input int buf_size,
    input int stm_base, input int off0, input int max0, input int off1, input int max1,
    input int stm_size);
    mem_ctrl_pkg::rd_cfg_t e;
    e.buf_base         = mem_ctrl_pkg::addr_t'(buf_base);
    e.buf_offset       = mem_ctrl_pkg::addr_t'(buf_offset);
    e.buf_loop_max     = mem_ctrl_pkg::loop_t'(buf_max);
    e.buf_size         = mem_ctrl_pkg::tx_size_t'(buf_size);
    e.stm_base         = mem_ctrl_pkg::addr_t'(stm_base);
    e.stm_loop0_offset = mem_ctrl_pkg::addr_t'(off0);
    e.stm_loop0_max    = mem_ctrl_pkg::loop_t'(max0);
    e.stm_loop1_offset = mem_ctrl_pkg::addr_t'(off1);
    e.stm_loop1_max    = mem_ctrl_pkg::loop_t'(max1);
    e.stm_size         = mem_ctrl_pkg::tx_size_t'(stm_size);
    return e;
  endfunction

  function automatic mem_ctrl_pkg::wr_cfg_t build_wr_entry(
    input int base, input int offset, input int loop_max, input int size);
    mem_ctrl_pkg::wr_cfg_t e;
    e.base     = mem_ctrl_pkg::addr_t'(base);
    e.offset   = mem_ctrl_pkg::addr_t'(offset);
    e.loop_max = mem_ctrl_pkg::loop_t'(loop_max);
    e.size     = mem_ctrl_pkg::tx_size_t'(size);
    return e;
  endfunction

  // ********************************************************************
  // table loading one entry per cycle
  // ********************************************************************
  task automatic load_rd_entry(input int idx, input mem_ctrl_pkg::rd_cfg_t entry);
    mem_ctrl_pkg::cfg_load_t item;
    item          = '0;
    item.we       = 1'b1;
    item.sel_wr   = 1'b0;
    item.idx      = mem_ctrl_pkg::rd_idx_t'(idx);
    item.rd_entry = entry;
    rd_tab[idx]   = entry;
    @(posedge clk);
    cfg_load <= item;
  endtask

  task automatic load_wr_entry(input int idx, input mem_ctrl_pkg::wr_cfg_t entry);
    mem_ctrl_pkg::cfg_load_t item;
    item          = '0;
    item.we       = 1'b1;
    item.sel_wr   = 1'b1;
    item.idx      = mem_ctrl_pkg::wr_idx_t'(idx);
    item.wr_entry = entry;
    wr_tab[idx]   = entry;
    @(posedge clk);
    cfg_load <= item;
  endtask

  // ********************************************************************
  // reference model
  // ********************************************************************
  task automatic build_read_model(input int last);
    mem_ctrl_pkg::rd_cfg_t c;
    mem_ctrl_pkg::rd_cmd_t cmd;
    int                    n;
    rd_exp.delete();
    for (int e = 0; e <= last; e++) begin
      c = rd_tab[e];
      for (int j = 0; j <= int'(c.stm_loop1_max); j++) begin
        for (int i = 0; i <= int'(c.stm_loop0_max); i++) begin
          for (int k = 0; k <= int'(c.buf_loop_max); k++) begin
            n             = i * (int'(c.buf_loop_max) + 1) + k;  // steps since i was 0
            cmd.addr      = c.buf_base + mem_ctrl_pkg::addr_t'(n) * c.buf_offset;
            cmd.size      = c.buf_size;
            cmd.pu_id     = mem_ctrl_pkg::pu_id_t'(k);
            cmd.is_buffer = 1'b1;
            rd_exp.push_back(cmd);
          end
          cmd.addr      = c.stm_base + mem_ctrl_pkg::addr_t'(j) * c.stm_loop1_offset
                          + mem_ctrl_pkg::addr_t'(i) * c.stm_loop0_offset;
          cmd.size      = c.stm_size;
          cmd.pu_id     = '0;
          cmd.is_buffer = 1'b0;
          rd_exp.push_back(cmd);
        end
      end
    end
  endtask

  task automatic build_write_model(input int last);
    mem_ctrl_pkg::wr_cmd_t cmd;
    wr_exp.delete();
    for (int e = 0; e <= last; e++) begin
      for (int n = 0; n <= int'(wr_tab[e].loop_max); n++) begin
        cmd.addr  = wr_tab[e].base + mem_ctrl_pkg::addr_t'(n) * wr_tab[e].offset;
        cmd.size  = wr_tab[e].size;
        cmd.pu_id = mem_ctrl_pkg::pu_id_t'(n % mem_ctrl_pkg::NUM_PU);
        wr_exp.push_back(cmd);
      end
    end
  endtask

  // start one run and wait for done plus all expected reads
  task automatic run_sequence(input int rd_last, input int wr_last);
    @(posedge clk);
    cfg_load    <= '0;
    rd_last_idx <= mem_ctrl_pkg::rd_idx_t'(rd_last);
    wr_last_idx <= mem_ctrl_pkg::wr_idx_t'(wr_last);
    rd_got.delete();
    wr_got.delete();
    done_cnt    = 0;
    wr_done_cnt = 0;
    wr_n        = 0;
    wr_ent      = 0;
    wr_entries  = wr_last + 1;
    build_read_model(rd_last);
    build_write_model(wr_last);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while ((done_cnt == 0) || (rd_got.size() < rd_exp.size())) @(negedge clk);
    repeat (10) @(negedge clk);   // catch extra requests
  endtask

  task automatic compare_results();
    if (rd_got.size() != rd_exp.size()) value_error("read count", rd_exp.size(), rd_got.size());
    for (int n = 0; (n < rd_got.size()) && (n < rd_exp.size()); n++) begin
      if (rd_got[n] !== rd_exp[n]) value_error($sformatf("read %0d", n), rd_exp[n], rd_got[n]);
    end
    if (wr_got.size() != wr_exp.size()) value_error("write count", wr_exp.size(), wr_got.size());
    for (int n = 0; (n < wr_got.size()) && (n < wr_exp.size()); n++) begin
      if (wr_got[n] !== wr_exp[n]) value_error($sformatf("write %0d", n), wr_exp[n], wr_got[n]);
    end
    if (done_cnt != 1) value_error("done pulses", 1, done_cnt);
  endtask

  task automatic report_test(input int err_before);
    tests_run++;
    if (err_count == err_before) begin
      $display("%s passed", test_name);
    end else begin
      tests_failed++;
      $display("%s failed with %0d errors", test_name, err_count - err_before);
    end
  endtask

  // ********************************************************************
  // directed tests
  // ********************************************************************
  task automatic test_after_reset();
    int err_before;
    test_name  = "after_reset";
    err_before = err_count;
    @(negedge clk);
    if (rd_req !== 1'b0) value_error("rd_req", 0, rd_req);
    if (wr_req !== 1'b0) value_error("wr_req", 0, wr_req);
    if (done !== 1'b0) value_error("done", 0, done);
    if (rd_cfg_idx !== '0) value_error("rd_cfg_idx", 0, rd_cfg_idx);
    if (wr_cfg_idx !== '0) value_error("wr_cfg_idx", 0, wr_cfg_idx);
    report_test(err_before);
  endtask

  task automatic test_single_read();
    int err_before;
    test_name  = "single_read";
    err_before = err_count;
    rd_rand    = 1'b0;
    wr_rand    = 1'b0;
    load_rd_entry(0, build_rd_entry(32'h1000, 32'h40, 2, 16, 32'h8000, 32'h100, 2,
                                    32'h1000, 1, 64));
    load_wr_entry(0, build_wr_entry(32'h20000, 32'h20, 3, 32));
    run_sequence(0, 0);
    compare_results();
    report_test(err_before);
  endtask

  task automatic test_random_rd_ready();
    int err_before;
    test_name  = "random_rd_ready";
    err_before = err_count;
    rd_rand    = 1'b1;
    wr_rand    = 1'b0;
    load_rd_entry(0, build_rd_entry(32'h1000, 32'h40, 2, 16, 32'h8000, 32'h100, 2,
                                    32'h1000, 1, 64));
    load_wr_entry(0, build_wr_entry(32'h20000, 32'h20, 3, 32));
    run_sequence(0, 0);
    compare_results();
    report_test(err_before);
  endtask

  task automatic test_single_write();
    int err_before;
    test_name  = "single_write";
    err_before = err_count;
    rd_rand    = 1'b0;
    wr_rand    = 1'b1;
    load_rd_entry(0, build_rd_entry(32'h3000, 32'h10, 1, 8, 32'h9000, 32'h80, 1, 0, 0, 8));
    load_wr_entry(0, build_wr_entry(32'h40000, 32'h44, 5, 12));
    run_sequence(0, 0);
    compare_results();
    report_test(err_before);
  endtask

  // the long first write entry holds the read side back at entry 1
  task automatic test_three_entries();
    int err_before;
    test_name  = "three_entries";
    err_before = err_count;
    rd_rand    = 1'b1;
    wr_rand    = 1'b1;
    load_rd_entry(0, build_rd_entry(32'h0100, 32'h8, 1, 4, 32'ha000, 32'h10, 1, 32'h200, 1, 20));
    load_rd_entry(1, build_rd_entry(32'h0500, 32'hc, 0, 6, 32'hb000, 32'h24, 2, 32'h400, 0, 30));
    load_rd_entry(2, build_rd_entry(32'h0900, 32'h4, 3, 2, 32'hc000, 32'h30, 0, 32'h800, 1, 40));
    load_wr_entry(0, build_wr_entry(32'h50000, 32'h10, 39, 16));
    load_wr_entry(1, build_wr_entry(32'h60000, 32'h18, 0, 24));
    load_wr_entry(2, build_wr_entry(32'h70000, 32'h08, 4, 8));
    run_sequence(2, 2);
    compare_results();
    report_test(err_before);
  endtask

// File: tests/mem_controller_tb.sv
// testbench top with clock, reset, dut, write memory model, monitor, watchdog and test calls
`timescale 1ns/100ps

module mem_controller_tb;

  // requests per test from the entries each test loads
  localparam int SINGLE_REQS     = 24 + 4;              // (3 buffer + 1 stream) x 3 x 2, 4 writes
  localparam int WRITE_REQS      = 6 + 6;
  localparam int MULTI_REQS      = 12 + 6 + 10 + 40 + 1 + 5;
  localparam int TOTAL_REQS      = 2 * SINGLE_REQS + WRITE_REQS + MULTI_REQS;
  localparam int SETUP_CYCLES    = 200;                 // reset, table loads and settle time
  localparam int WATCHDOG_CYCLES = 40 * TOTAL_REQS + SETUP_CYCLES;

  logic                    clk;
  logic                    reset;
  logic                    start;
  logic                    done;
  logic                    rd_req;
  logic                    rd_ready;
  logic                    wr_req;
  logic                    wr_ready;
  logic                    wr_done;
  mem_ctrl_pkg::cfg_load_t cfg_load;
  mem_ctrl_pkg::rd_idx_t   rd_last_idx;
  mem_ctrl_pkg::wr_idx_t   wr_last_idx;
  mem_ctrl_pkg::rd_cmd_t   rd_cmd;
  mem_ctrl_pkg::wr_cmd_t   wr_cmd;
  mem_ctrl_pkg::rd_idx_t   rd_cfg_idx;
  mem_ctrl_pkg::wr_idx_t   wr_cfg_idx;

  integer seed = 32'ha1a3d30a;
  string  test_name = "reset";
  int     err_count;
  int     tests_run;
  int     tests_failed;
  bit     rd_rand;          // random rd_ready when set
  bit     wr_rand;          // random wr_ready when set

  // copies of what was loaded into the dut tables
  mem_ctrl_pkg::rd_cfg_t rd_tab [mem_ctrl_pkg::RD_DEPTH];
  mem_ctrl_pkg::wr_cfg_t wr_tab [mem_ctrl_pkg::WR_DEPTH];
  mem_ctrl_pkg::rd_cmd_t rd_got [$];
  mem_ctrl_pkg::rd_cmd_t rd_exp [$];
  mem_ctrl_pkg::wr_cmd_t wr_got [$];
  mem_ctrl_pkg::wr_cmd_t wr_exp [$];

  int done_cnt;
  int wr_done_cnt;
  int wr_entries;           // write entries in the current run
  int wr_n;                 // writes seen in the current entry
  int wr_ent;
  int done_wait;            // cycles left until wr_done or 0
  bit rd_req_q;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  mem_controller mem_controller_i (
    .clk(clk), .reset(reset), .cfg_load(cfg_load), .rd_last_idx(rd_last_idx),
    .wr_last_idx(wr_last_idx), .start(start), .done(done), .rd_req(rd_req),
    .rd_ready(rd_ready), .rd_cmd(rd_cmd), .wr_req(wr_req), .wr_ready(wr_ready),
    .wr_done(wr_done), .wr_cmd(wr_cmd), .rd_cfg_idx(rd_cfg_idx), .wr_cfg_idx(wr_cfg_idx)
  );

  `include "mem_controller_tests.svh"

  // ********************************************************************
  // ready drivers and write memory completion
  // ********************************************************************
  always @(posedge clk) begin
    rd_ready <= rd_rand ? random_bit() : 1'b1;
    wr_ready <= wr_rand ? random_bit() : 1'b1;
    wr_done  <= (done_wait == 1);
    if (done_wait > 0) done_wait = done_wait - 1;
  end

  // ********************************************************************
  // monitor sampling mid cycle
  // ********************************************************************
  always @(negedge clk) begin
    if (!reset) begin
      if (rd_req && !rd_ready) flag_error("read request while rd_ready was low");
      if (rd_req && rd_req_q) flag_error("read requests in two consecutive cycles");
      if (rd_req && (rd_cfg_idx > wr_cfg_idx)) flag_error("read issued ahead of the write entry");
      if (wr_req && (!wr_ready || wr_done)) begin
        flag_error("write request without wr_ready or with wr_done");
      end
      if (wr_req && (done_wait > 0)) flag_error("write request before the entry's wr_done");
      if (rd_req) rd_got.push_back(rd_cmd);
      if (wr_req) begin
        wr_got.push_back(wr_cmd);
        wr_n++;
        if ((wr_ent < mem_ctrl_pkg::WR_DEPTH) && (wr_n == int'(wr_tab[wr_ent].loop_max) + 1)) begin
          wr_n      = 0;
          wr_ent++;
          done_wait = random_delay();   // last write of the entry
        end
      end
      if (wr_done) wr_done_cnt++;
      if (done) begin
        done_cnt++;
        if (!wr_done || (wr_done_cnt != wr_entries)) begin
          flag_error("done did not come with the last write completion");
        end
      end
      rd_req_q = rd_req;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    start       = 1'b0;
    cfg_load    = '0;
    rd_last_idx = '0;
    wr_last_idx = '0;
    rd_ready    = 1'b1;
    wr_ready    = 1'b1;
    wr_done     = 1'b0;
    rd_rand     = 1'b0;
    wr_rand     = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_after_reset();
    test_single_read();
    test_random_rd_ready();
    test_single_write();
    test_three_entries();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
